// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // widths of the three icache address fields
    localparam int OFFSET_W   = 4;                       // 16 byte lines
    localparam int INDEX_W    = 8;                       // 256 lines
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;  // whatever is left
    localparam int NUM_LINES  = 1 << INDEX_W;
    localparam int LINE_WORDS = 1 << (OFFSET_W - 2);     // four words per line

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // cp0 style exception code
    typedef logic [4:0] exc_code_t;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [OFFSET_W-3:0] word_sel_t;  // word slot inside a line

    localparam exc_code_t EXC_ADEL = 5'd4;    // address error on load / fetch
    localparam exc_code_t EXC_NONE = 5'h1f;   // no exception

    // icache controller states
    typedef enum logic [1:0] {
        CS_IDLE,     // waiting for a request, addr_ok high
        CS_LOOKUP,   // tag compare on the latched address
        CS_REFILL,   // pulling the line from memory word by word
        CS_RESPOND   // line complete, answer from the array
    } cache_state_t;

endpackage

`default_nettype wire

// File: icache_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_if;
    import fetch_pkg::*;

    // request side, driven by fetch
    logic    valid;    // held until addr_ok
    index_t  index;
    tag_t    tag;
    offset_t offset;

    // response side, driven by the cache
    logic    addr_ok;  // request taken this cycle if valid too
    logic    data_ok;  // one cycle per accepted request
    inst_t   rdata;    // good only with data_ok

    modport fetch (
        output valid,
        output index,
        output tag,
        output offset,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport cache (
        input  valid,
        input  index,
        input  tag,
        input  offset,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
    parameter fetch_pkg::addr_t RESET_PC   = 32'hbfbffffc,
    parameter fetch_pkg::addr_t EXC_VECTOR = 32'hbfc00380
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ds_allowin,     // decode can take fs
    input  wire                        br_taken,
    input  wire                        br_stall,       // branch operands not ready
    input  wire                        br_delay_slot,
    input  wire                        mfc0_stall,
    input  wire                        flush,          // exception from later stage
    input  wire                        eret,
    input  wire fetch_pkg::addr_t      br_target,
    input  wire fetch_pkg::addr_t      epc,
    icache_if.fetch                    icache,
    output logic                       fs_valid,
    output logic                       fs_ex,
    output logic                       fs_bd,
    output fetch_pkg::addr_t           fs_pc,
    output fetch_pkg::inst_t           fs_inst,
    output fetch_pkg::exc_code_t       fs_exc_code
);
    import fetch_pkg::*;

    addr_t nextpc;          // pc picked by priority
    addr_t req_pc;          // pc of the request in progress
    logic  req_bd;          // delay slot flag travelling with the request
    logic  req_valid;       // registered request level
    logic  in_flight;       // accepted, data_ok not seen yet
    logic  flush_pending;   // flush arrived while busy
    logic  busy;
    logic  take;            // fs contents leave this cycle
    logic  boot;            // nothing held, nothing pending
    logic  drop;            // stale response after a flush
    logic  choose;          // nextpc is picked this cycle
    logic  misaligned;
    logic  br_go;
    logic  accept;

    assign busy   = req_valid | in_flight;
    assign take   = fs_valid & (ds_allowin | flush);  // flush kills a held inst
    assign boot   = ~fs_valid & ~busy;                // only right after reset
    assign drop   = icache.data_ok & (flush_pending | flush);
    assign choose = take | boot | drop;
    assign accept = icache.valid & icache.addr_ok;
    assign br_go  = br_taken & ~br_stall & ~mfc0_stall;

    // eret > flush > taken branch > sequential
    always_comb begin
        if (eret) begin
            nextpc = epc;
        end else if (flush | flush_pending) begin
            nextpc = EXC_VECTOR;
        end else if (br_go) begin
            nextpc = br_target;
        end else begin
            nextpc = fs_pc + 32'd4;
        end
    end

    assign misaligned = nextpc[1:0] != 2'b00;  // adel, never reaches the cache

    // request level, up the cycle after the pick, down on acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (choose & ~misaligned) begin
            req_valid <= 1'b1;
        end else if (accept) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (accept) begin
            in_flight <= 1'b1;
        end else if (icache.data_ok) begin
            in_flight <= 1'b0;
        end
    end

    // remember a flush that hit an outstanding request
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_pending <= 1'b0;
        end else if (choose) begin
            flush_pending <= 1'b0;  // consumed by this pick
        end else if (flush & busy) begin
            flush_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            fs_pc    <= RESET_PC;
        end else if (choose) begin
            fs_valid <= misaligned;   // bad pc goes straight to decode
            if (misaligned) begin
                fs_pc <= nextpc;
            end
        end else if (icache.data_ok) begin
            fs_valid <= 1'b1;
            fs_pc    <= req_pc;
        end
    end

    // payload of fs
    always_ff @(posedge clk) begin
        if (choose & misaligned) begin
            fs_inst <= '0;
            fs_bd   <= br_delay_slot;
        end else if (icache.data_ok & ~drop) begin
            fs_inst <= icache.rdata;
            fs_bd   <= req_bd;
        end
    end

    // payload of the request
    always_ff @(posedge clk) begin
        if (choose & ~misaligned) begin
            req_pc <= nextpc;
            req_bd <= br_delay_slot;
        end
    end

    assign icache.valid = req_valid;
    assign {icache.tag, icache.index, icache.offset} = req_pc;

    // exception tag follows the held pc
    assign fs_ex       = fs_pc[1:0] != 2'b00;
    assign fs_exc_code = fs_ex ? EXC_ADEL : EXC_NONE;

endmodule

`default_nettype wire

// File: inst_cache.sv
`timescale 1ns/1ns
`default_nettype none

module inst_cache (
    input  wire                    clk,
    input  wire                    reset,
    icache_if.cache                icache,
    output logic                   mem_req,     // one word wanted
    output fetch_pkg::addr_t       mem_addr,    // word aligned
    input  wire                    mem_ready,   // mem_rdata good this cycle
    input  wire fetch_pkg::inst_t  mem_rdata
);
    import fetch_pkg::*;

    localparam word_sel_t LAST_WORD = word_sel_t'(LINE_WORDS - 1);

    cache_state_t state;

    // line storage
    tag_t                 tag_arr  [NUM_LINES];
    inst_t                data_arr [NUM_LINES][LINE_WORDS];
    logic [NUM_LINES-1:0] valid_arr;

    // latched request
    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;

    word_sel_t fill_cnt;     // next word to pull in
    logic      hit;
    logic      fill_last;    // fourth word arriving
    logic      fill_word;    // some word arriving

    assign hit       = valid_arr[req_index] & (tag_arr[req_index] == req_tag);
    assign fill_word = (state == CS_REFILL) & mem_ready;
    assign fill_last = fill_word & (fill_cnt == LAST_WORD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= CS_IDLE;
            fill_cnt <= '0;
        end else begin
            case (state)
                CS_IDLE: begin
                    if (icache.valid) begin
                        state <= CS_LOOKUP;
                    end
                end
                CS_LOOKUP: begin
                    if (hit) begin
                        state <= CS_IDLE;   // answered this cycle
                    end else begin
                        state    <= CS_REFILL;
                        fill_cnt <= '0;     // lowest word first
                    end
                end
                CS_REFILL: begin
                    if (mem_ready) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == LAST_WORD) begin
                            state <= CS_RESPOND;
                        end
                    end
                end
                CS_RESPOND: begin
                    state <= CS_IDLE;
                end
                default: begin
                    state <= CS_IDLE;
                end
            endcase
        end
    end

    // accept only when idle
    always_ff @(posedge clk) begin
        if ((state == CS_IDLE) & icache.valid) begin
            req_tag   <= icache.tag;
            req_index <= icache.index;
            req_word  <= icache.offset[OFFSET_W-1:2];  // byte bits ignored
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_arr <= '0;
        end else if ((state == CS_LOOKUP) & ~hit) begin
            valid_arr[req_index] <= 1'b0;  // line is being replaced
        end else if (fill_last) begin
            valid_arr[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_last) begin
            tag_arr[req_index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_word) begin
            data_arr[req_index][fill_cnt] <= mem_rdata;
        end
    end

    assign icache.addr_ok = state == CS_IDLE;
    assign icache.data_ok = ((state == CS_LOOKUP) & hit) | (state == CS_RESPOND);
    assign icache.rdata   = data_arr[req_index][req_word];

    // memory side, held for the whole refill
    assign mem_req  = state == CS_REFILL;
    assign mem_addr = {req_tag, req_index, fill_cnt, 2'b00};

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC   = 32'hbfbffffc,  // one word below boot
    parameter fetch_pkg::addr_t EXC_VECTOR = 32'hbfc00380
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ds_allowin,
    input  wire                        br_taken,
    input  wire                        br_stall,
    input  wire fetch_pkg::addr_t      br_target,
    input  wire                        br_delay_slot,
    input  wire                        flush,
    input  wire                        eret,
    input  wire fetch_pkg::addr_t      epc,
    input  wire                        mfc0_stall,
    input  wire                        mem_ready,
    input  wire fetch_pkg::inst_t      mem_rdata,
    output logic                       fs_valid,
    output fetch_pkg::addr_t           fs_pc,
    output fetch_pkg::inst_t           fs_inst,
    output logic                       fs_ex,
    output fetch_pkg::exc_code_t       fs_exc_code,
    output logic                       fs_bd,
    output logic                       mem_req,
    output fetch_pkg::addr_t           mem_addr
);

    icache_if icache ();  // fetch to cache request path

    fetch_stage #(
        .RESET_PC   (RESET_PC),
        .EXC_VECTOR (EXC_VECTOR)
    ) u_fetch_stage (
        .clk           (clk),
        .reset         (reset),
        .ds_allowin    (ds_allowin),
        .br_taken      (br_taken),
        .br_stall      (br_stall),
        .br_delay_slot (br_delay_slot),
        .mfc0_stall    (mfc0_stall),
        .flush         (flush),
        .eret          (eret),
        .br_target     (br_target),
        .epc           (epc),
        .icache        (icache.fetch),
        .fs_valid      (fs_valid),
        .fs_ex         (fs_ex),
        .fs_bd         (fs_bd),
        .fs_pc         (fs_pc),
        .fs_inst       (fs_inst),
        .fs_exc_code   (fs_exc_code)
    );

    inst_cache u_inst_cache (
        .clk       (clk),
        .reset     (reset),
        .icache    (icache.cache),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker (
    input wire clk,
    input wire reset,
    input wire valid,
    input wire addr_ok,
    input wire data_ok,
    input wire mem_req,
    input wire mem_ready
);
    logic pending;  // accepted and no data_ok yet
    int   fails = 0;  // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (valid & addr_ok) begin
            pending <= 1'b1;
        end else if (data_ok) begin
            pending <= 1'b0;
        end
    end

    // a response needs a request behind it
    a_data_ok_owed: assert property (@(posedge clk) disable iff (reset) data_ok |-> pending)
        else begin
            $error("data_ok without an accepted request");
            fails++;
        end

    a_mem_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req & ~mem_ready |=> mem_req)
        else begin
            $error("mem_req dropped before mem_ready");
            fails++;
        end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        pending |-> ~(valid & addr_ok))
        else begin
            $error("request accepted while a response is pending");
            fails++;
        end

endmodule

bind inst_cache fetch_checker u_fetch_checker (
    .clk       (clk),
    .reset     (reset),
    .valid     (icache.valid),
    .addr_ok   (icache.addr_ok),
    .data_ok   (icache.data_ok),
    .mem_req   (mem_req),
    .mem_ready (mem_ready)
);

`default_nettype wire

// File: fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic ds_allowin = 1'b0, br_taken = 1'b0, br_stall = 1'b0, br_delay_slot = 1'b0;
    logic flush = 1'b0, eret = 1'b0, mfc0_stall = 1'b0, mem_ready = 1'b0;
    addr_t br_target = '0, epc = '0, mem_addr;
    inst_t mem_rdata = '0, fs_inst;
    logic fs_valid, fs_ex, fs_bd, mem_req;
    addr_t fs_pc;
    exc_code_t fs_exc_code;

    logic [31:0] rng = 32'h14ef;        // memory delays
    logic [31:0] allow_rng = 32'h14ef;  // decode back-pressure
    logic [27:0] adel_line = '1;        // line of the misaligned target
    int errors = 0, checks = 0, loads = 0, mem_wait = 0, cycles = 0, limit = 100000;
    int adel_reqs = 0;
    string cmds[$];
    logic [31:0] opa[$], opb[$], exp_pc[$], exp_ex[$];

    fetch_top dut (.*);

    always #2 clk = ~clk;  // 4 ns

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // memory model answers each word after 1 to 3 cycles
    always @(negedge clk) begin
        mem_ready = 1'b0;
        if (!reset && mem_req) begin
            if (mem_wait == 0) begin
                rng = xorshift(rng);
                mem_wait = 1 + rng % 3;
            end
            mem_wait--;
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem_addr ^ 32'ha5a50000;
            end
        end
    end

    always @(posedge clk) begin
        if (mem_req && mem_ready) loads++;  // refill words seen
        if (mem_req && mem_addr[31:4] == adel_line) adel_reqs++;
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_item(input addr_t pc, input logic ex, input logic bd);
        check("fs_pc", fs_pc, pc);
        check("fs_ex", fs_ex, ex);
        check("fs_exc_code", fs_exc_code, ex ? 32'd4 : 32'h1f);
        check("fs_inst", fs_inst, ex ? 32'h0 : pc ^ 32'ha5a50000);
        check("fs_bd", fs_bd, bd);
    endtask

    // decode takes the held item at this falling edge
    task automatic deliver(input logic br, st, mf, bd, fl, er, late_fl, input addr_t tgt, ep);
        ds_allowin = 1'b1;
        {br_taken, br_stall, mfc0_stall, br_delay_slot} = {br, st, mf, bd};
        {flush, eret, br_target, epc} = {fl, er, tgt, ep};
        @(negedge clk);
        {ds_allowin, br_taken, br_stall, mfc0_stall, br_delay_slot, flush, eret} = '0;
        if (late_fl) begin
            flush = 1'b1;  // hits the request in flight
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    // wait for the next item while random allowin holds it back
    task automatic present(input bit rnd);
        logic held, go;
        addr_t held_pc;
        inst_t held_inst;
        held = 1'b0;
        go = 1'b0;
        while (!go) begin
            if (held) begin
                check("fs_valid", fs_valid, 1);
                check("fs_pc", fs_pc, held_pc);
                check("fs_inst", fs_inst, held_inst);
            end
            held = 1'b0;
            if (fs_valid) begin
                if (rnd) begin
                    allow_rng = xorshift(allow_rng);
                    go = allow_rng[0];
                end else begin
                    go = 1'b1;
                end
                held = !go;
                held_pc = fs_pc;
                held_inst = fs_inst;
            end
            if (!go) @(negedge clk);
        end
    endtask

    initial begin
        int fd, i, err0;
        string line, cmd;
        logic [31:0] a, b, p, e;
        addr_t pc_model;
        fd = $fopen("fetch_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%s %h %h %h %h", cmd, a, b, p, e) == 5) begin
                    cmds.push_back(cmd);
                    opa.push_back(a);
                    opb.push_back(b);
                    exp_pc.push_back(p);
                    exp_ex.push_back(e);
                end
            end
            $fclose(fd);
        end
        limit = 60 * (cmds.size() + 1);
        repeat (3) @(negedge clk);
        reset = 1'b0;
        present(0);
        check_item(32'hbfc00000, 1'b0, 1'b0);  // boot vector first
        $display("test 0 boot: %0d errors", errors);
        for (i = 0; i < cmds.size(); i++) begin
            err0 = errors;
            loads = 0;
            cmd = cmds[i];
            a = opa[i];
            b = opb[i];
            pc_model = fs_pc;
            case (cmd)
                "run", "stall": begin
                    repeat (a) begin
                        deliver(0, 0, 0, 0, 0, 0, 0, 0, 0);
                        present(cmd == "stall");
                        pc_model += 4;
                        check_item(pc_model, 1'b0, 1'b0);  // no gap and no repeat
                    end
                end
                "branch": deliver(1, b[1], b[2], b[0], 0, 0, 0, a, 0);
                "misalign": begin
                    adel_line = a[31:4];  // never refilled from here on
                    deliver(1, b[1], b[2], b[0], 0, 0, 0, a, 0);
                end
                "flush": deliver(0, 0, 0, 0, !a[0], 0, a[0], 0, 0);
                "eret": deliver(0, 0, 0, 0, b[0], 1, 0, 0, a);
                "loop": begin
                    deliver(1, 0, 0, 0, 0, 0, 0, a, 0);
                    present(0);
                    check_item(a, 1'b0, 1'b0);
                    pc_model = a;
                    repeat (b) begin
                        deliver(0, 0, 0, 0, 0, 0, 0, 0, 0);
                        present(0);
                        pc_model += 4;
                        check_item(pc_model, 1'b0, 1'b0);
                    end
                end
                default: begin
                    errors++;
                    $display("unknown command %s in the stimulus file", cmd);
                end
            endcase
            if (cmd == "branch" || cmd == "misalign" || cmd == "flush" || cmd == "eret")
                present(0);
            check_item(exp_pc[i], exp_ex[i][0], cmd == "branch" ? b[0] : 1'b0);
            if (cmd == "loop") check("refill words", loads, 0);
            $display("test %0d %s: %0d errors", i + 1, cmd, errors - err0);
        end
        check("mem_req for misaligned pc", adel_reqs, 0);
        check("checker failures", dut.u_inst_cache.u_fetch_checker.fails, 0);
        $display("%0d tests, %0d checks, %0d errors", cmds.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_stimulus.txt
# command  operand_a  operand_b  expected_pc  expected_ex (all hex)
# branch flags in operand_b: bit0 delay slot, bit1 br_stall, bit2 mfc0_stall
run      7        0  bfc0001c  0
loop     bfc00000 7  bfc0001c  0
branch   bfc00100 1  bfc00100  0
branch   bfc00200 2  bfc00104  0
branch   bfc00200 4  bfc00108  0
run      2        0  bfc00110  0
flush    0        0  bfc00380  0
run      1        0  bfc00384  0
flush    1        0  bfc00380  0
eret     bfc00040 0  bfc00040  0
eret     bfc00060 1  bfc00060  0
misalign bfc00402 0  bfc00402  1
flush    0        0  bfc00380  0
stall    c        0  bfc003b0  0
branch   bfc00500 0  bfc00500  0
stall    6        0  bfc00518  0

// File: fetch_unit.f
fetch_pkg.sv
icache_if.sv
fetch_stage.sv
inst_cache.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv
